// File: score_display.f
+incdir+verilog
verilog/score_pkg.sv
verilog/game_phase_fsm.sv
verilog/bcd_score_counter.sv
verilog/seven_seg_decoder.sv
verilog/digit_window.sv
verilog/digit_stroke_renderer.sv
verilog/digit_overlay.sv
verilog/score_display.sv
bench/score_display_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ns --top-module score_display_tb \
    -f score_display.f -o score_display_sim || exit 1
out=$(./obj_dir/score_display_sim 2>&1)
echo "$out"
echo "$out" | grep -qF "All tests passed!" \
    && echo "Simulation PASSED" \
    || { echo "Simulation FAILED"; exit 1; }

// File: bench/score_display_tb.sv
`timescale 1ns/1ns
`include "score_defines.svh"

module score_display_tb;

    localparam int TIMEOUT_CYCLES = 4000; // Tests take about 1600 cycles.

    logic                               clk;
    logic                               rst_n;
    score_pkg::pixel_t                  pixel;
    logic                               point;
    logic [2:0]                         point_amount;
    logic                               game_over;
    logic                               restart;
    score_pkg::seg_t [`DIGIT_COUNT-1:0] ss;
    logic                               digit_draw;
    logic [7:0]                         digit_rgb;
    score_pkg::phase_e                  phase;

    integer            seed;
    int                model_score;
    bit                model_over;
    int                cycles = 0;
    logic              scan_active;
    score_pkg::pixel_t pix_q;
    logic              pix_valid_q = 1'b0;

    score_display score_display_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .pixel        (pixel),
        .point        (point),
        .point_amount (point_amount),
        .game_over    (game_over),
        .restart      (restart),
        .ss           (ss),
        .digit_draw   (digit_draw),
        .digit_rgb    (digit_rgb),
        .phase        (phase)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [6:0] seg_pattern(input int d);
        logic [6:0] pat;
        case (d)
            0:       pat = 7'b1000000;
            1:       pat = 7'b1111001;
            2:       pat = 7'b0100100;
            3:       pat = 7'b0110000;
            4:       pat = 7'b0011001;
            5:       pat = 7'b0010010;
            6:       pat = 7'b0000010;
            7:       pat = 7'b1111000;
            8:       pat = 7'b0000000;
            9:       pat = 7'b0010000;
            default: pat = 7'b1111111;
        endcase
        return pat;
    endfunction

    function automatic logic [20:0] expected_ss(input int score);
        return {seg_pattern((score / 100) % 10), seg_pattern((score / 10) % 10),
                seg_pattern(score % 10)};
    endfunction

    // Segment index under a grid cell, -1 off every stroke.
    function automatic int stroke_segment(input int ox, input int oy);
        int  idx;
        bit  mid;
        idx = -1;
        mid = (ox >= 1) && (ox <= 4);
        if (oy == 0 && mid) idx = 0;
        else if (oy >= 1 && oy <= 3 && ox == 5) idx = 1;
        else if (oy >= 1 && oy <= 3 && ox == 0) idx = 5;
        else if (oy == 4 && mid) idx = 6;
        else if (oy >= 5 && oy <= 8 && ox == 5) idx = 2;
        else if (oy >= 5 && oy <= 8 && ox == 0) idx = 4;
        else if (oy == 9 && mid) idx = 3;
        return idx;
    endfunction

    function automatic bit pixel_on(input int px, input int py, input bit over,
                                    input int score);
        int         shift;
        int         cx;
        int         cy;
        int         div;
        int         sidx;
        bit         found;
        bit         on;
        logic [6:0] pat;
        shift = over ? `SCALE_SHIFT : 0;
        cy    = over ? `LARGE_Y : `SMALL_Y;
        div   = 1;
        found = 1'b0;
        on    = 1'b0;
        for (int i = 0; i < `DIGIT_COUNT; i++) begin
            cx = over ? `LARGE_X - 80 * i : `SMALL_X - 10 * i;
            if (!found && px >= cx && px < cx + (`GLYPH_W << shift)
                    && py >= cy && py < cy + (`GLYPH_H << shift)) begin
                found = 1'b1;
                pat   = seg_pattern((score / div) % 10);
                sidx  = stroke_segment((px - cx) >> shift, (py - cy) >> shift);
                on    = (sidx >= 0) && !pat[3'(sidx)]; // Active low.
            end
            div = div * 10;
        end
        return on;
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
            $display("Test failures found");
            $fatal(1, "Stopped at the first wrong value.");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic add_point(input string name, input logic [2:0] amount);
        @(posedge clk);
        point        <= 1'b1;
        point_amount <= amount;
        @(posedge clk);
        point <= 1'b0;
        if (!model_over) model_score = (model_score + int'(amount)) % 1000;
        @(negedge clk);
        check(name, 32'(expected_ss(model_score)), 32'(ss));
    endtask

    task automatic phase_strobe(input bit to_over);
        @(posedge clk);
        game_over <= to_over;
        restart   <= !to_over;
        @(posedge clk);
        game_over <= 1'b0;
        restart   <= 1'b0;
        model_over = to_over;
        if (!to_over) model_score = 0; // Restart clears the score.
        @(negedge clk);
        check("phase change", 32'(model_over), 32'(phase));
        check("phase change score", 32'(expected_ss(model_score)), 32'(ss));
    endtask

    task automatic drive_pixel(input int px, input int py);
        @(posedge clk);
        pixel.x     <= `COORD_W'(px);
        pixel.y     <= `COORD_W'(py);
        scan_active <= 1'b1;
    endtask

    task automatic end_scan;
        @(posedge clk);
        scan_active <= 1'b0;
        @(posedge clk);
    endtask

    // Overlay output belongs to the pixel of the previous edge.
    always @(posedge clk) begin
        pix_q       <= pixel;
        pix_valid_q <= scan_active;
    end

    always @(negedge clk) begin
        if (pix_valid_q) begin
            check("overlay draw",
                  32'(pixel_on(int'(pix_q.x), int'(pix_q.y), model_over, model_score)),
                  32'(digit_draw));
            check("overlay rgb", 32'(model_over ? `OVER_RGB : `PLAY_RGB), 32'(digit_rgb));
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failures found");
            $fatal(1, "Simulation ran out of cycles.");
        end
    end

    initial begin
        int          px;
        int          py;
        logic [31:0] r;
        seed         = 61;
        model_score  = 0;
        model_over   = 1'b0;
        rst_n        = 1'b0;
        pixel.x      = `COORD_W'(`SMALL_X + 1); // Top bar of the small ones digit.
        pixel.y      = `COORD_W'(`SMALL_Y);
        point        = 1'b0;
        point_amount = 3'd0;
        game_over    = 1'b0;
        restart      = 1'b0;
        scan_active  = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check("reset phase", 32'(score_pkg::PLAYING), 32'(phase));
        check("reset draw", 32'd0, 32'(digit_draw));
        check("reset score", 32'(expected_ss(0)), 32'(ss));
        repeat (300) begin
            r = $random(seed);
            add_point("scoring", r[2:0]);
        end
        phase_strobe(1'b1);
        repeat (20) begin
            r = $random(seed);
            add_point("frozen score", r[2:0]);
        end
        repeat (400) begin
            r  = $random(seed);
            px = 232 + int'(r[15:0]) % 224; // Three large digits plus margin.
            r  = $random(seed);
            py = 192 + int'(r[15:0]) % 96;
            drive_pixel(px, py);
        end
        end_scan();
        phase_strobe(1'b0);
        repeat (40) begin
            r = $random(seed);
            add_point("new score", r[2:0]);
        end
        for (py = `SMALL_Y - 2; py < `SMALL_Y + `GLYPH_H + 2; py++) begin
            for (px = `SMALL_X - 22; px < `SMALL_X + `GLYPH_W + 2; px++) begin
                drive_pixel(px, py);
            end
        end
        end_scan();
        $display("All tests passed!");
        $finish;
    end

endmodule

// File: verilog/score_display.sv
`timescale 1ns/1ns
`include "score_defines.svh"

module score_display (
    input  logic                               clk,
    input  logic                               rst_n,
    input  score_pkg::pixel_t                  pixel,
    input  logic                               point,
    input  logic [2:0]                         point_amount,
    input  logic                               game_over,
    input  logic                               restart,
    output score_pkg::seg_t [`DIGIT_COUNT-1:0] ss,
    output logic                               digit_draw,
    output logic [7:0]                         digit_rgb,
    output score_pkg::phase_e                  phase
);

    logic                               count_en;
    logic                               score_clear;
    score_pkg::bcd_t [`DIGIT_COUNT-1:0] score_digits;

    ////////////////////////////////////////////////////////////////////////////
    // Game phase and score
    ////////////////////////////////////////////////////////////////////////////

    game_phase_fsm game_phase_fsm_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .game_over   (game_over),
        .restart     (restart),
        .phase       (phase),
        .count_en    (count_en),
        .score_clear (score_clear)
    );

    bcd_score_counter bcd_score_counter_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .point        (point),
        .point_amount (point_amount),
        .count_en     (count_en),
        .score_clear  (score_clear),
        .score_digits (score_digits)
    );

    genvar i;
    generate
        for (i = 0; i < `DIGIT_COUNT; i++) begin : g_decoder
            seven_seg_decoder seven_seg_decoder_i (
                .digit (score_digits[i]),
                .seg   (ss[i])
            );
        end
    endgenerate

    ////////////////////////////////////////////////////////////////////////////
    // On-screen overlay
    ////////////////////////////////////////////////////////////////////////////

    digit_overlay digit_overlay_i (
        .clk   (clk),
        .rst_n (rst_n),
        .pixel (pixel),
        .phase (phase),
        .ss    (ss),     // Glyphs share the board's segment patterns.
        .draw  (digit_draw),
        .rgb   (digit_rgb)
    );

endmodule

// File: verilog/digit_overlay.sv
`timescale 1ns/1ns
`include "score_defines.svh"

module digit_overlay (
    input  logic                              clk,
    input  logic                              rst_n,
    input  score_pkg::pixel_t                 pixel,
    input  score_pkg::phase_e                 phase,
    input  score_pkg::seg_t [`DIGIT_COUNT-1:0] ss,
    output logic                              draw,
    output logic [7:0]                        rgb
);

    localparam int SMALL_PITCH = 10;                          // Glyph plus gap.
    localparam int LARGE_PITCH = SMALL_PITCH << `SCALE_SHIFT;

    score_pkg::digit_hit_t [`DIGIT_COUNT-1:0] small_hit;
    score_pkg::digit_hit_t [`DIGIT_COUNT-1:0] large_hit;
    score_pkg::digit_hit_t [`DIGIT_COUNT-1:0] sel_hit;
    score_pkg::digit_hit_t                    pick_hit;
    score_pkg::seg_t                          pick_seg;

    ////////////////////////////////////////////////////////////////////////////
    // Windows per digit
    ////////////////////////////////////////////////////////////////////////////

    genvar i;
    generate
        for (i = 0; i < `DIGIT_COUNT; i++) begin : g_digit
            digit_window #(
                .DIGIT_SHIFT (0),
                .CORNER_X    (`SMALL_X - SMALL_PITCH * i),
                .CORNER_Y    (`SMALL_Y)
            ) small_window_i (
                .pixel (pixel),
                .hit   (small_hit[i])
            );

            digit_window #(
                .DIGIT_SHIFT (`SCALE_SHIFT),
                .CORNER_X    (`LARGE_X - LARGE_PITCH * i),
                .CORNER_Y    (`LARGE_Y)
            ) large_window_i (
                .pixel (pixel),
                .hit   (large_hit[i])
            );
        end
    endgenerate

    assign sel_hit = (phase == score_pkg::OVER) ? large_hit : small_hit;

    // Walk down so the lowest hit index is written last.
    always_comb begin
        pick_hit = '0;
        pick_seg = '1;
        for (int j = `DIGIT_COUNT - 1; j >= 0; j--) begin
            if (sel_hit[j].hit) begin
                pick_hit = sel_hit[j];
                pick_seg = ss[j];
            end
        end
    end

    digit_stroke_renderer digit_stroke_renderer_i (
        .clk   (clk),
        .rst_n (rst_n),
        .hit   (pick_hit),
        .seg   (pick_seg),
        .phase (phase),
        .draw  (draw),
        .rgb   (rgb)
    );

endmodule

// File: verilog/digit_stroke_renderer.sv
`timescale 1ns/1ns
`include "score_defines.svh"

module digit_stroke_renderer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  score_pkg::digit_hit_t hit,
    input  score_pkg::seg_t       seg,
    input  score_pkg::phase_e     phase,
    output logic                  draw,
    output logic [7:0]            rgb
);

    logic left_col;
    logic right_col;
    logic mid_col;
    logic upper_rows;
    logic lower_rows;
    logic on_stroke;

    assign left_col   = (hit.off_x == 3'd0);
    assign right_col  = (hit.off_x == 3'd5);
    assign mid_col    = (hit.off_x >= 3'd1) && (hit.off_x <= 3'd4);
    assign upper_rows = (hit.off_y >= 4'd1) && (hit.off_y <= 4'd3);
    assign lower_rows = (hit.off_y >= 4'd5) && (hit.off_y <= 4'd8);

    ////////////////////////////////////////////////////////////////////////////
    // Stroke map, segment on when its bit is low
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        on_stroke = 1'b0;
        if (!seg[0] && hit.off_y == 4'd0 && mid_col) begin
            on_stroke = 1'b1; // a
        end
        if (!seg[1] && upper_rows && right_col) begin
            on_stroke = 1'b1; // b
        end
        if (!seg[2] && lower_rows && right_col) begin
            on_stroke = 1'b1; // c
        end
        if (!seg[3] && hit.off_y == 4'd9 && mid_col) begin
            on_stroke = 1'b1; // d
        end
        if (!seg[4] && lower_rows && left_col) begin
            on_stroke = 1'b1; // e
        end
        if (!seg[5] && upper_rows && left_col) begin
            on_stroke = 1'b1; // f
        end
        if (!seg[6] && hit.off_y == 4'd4 && mid_col) begin
            on_stroke = 1'b1; // g
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            draw <= 1'b0;
            rgb  <= '0;
        end else begin
            draw <= hit.hit && on_stroke;
            rgb  <= (phase == score_pkg::OVER) ? `OVER_RGB : `PLAY_RGB;
        end
    end

endmodule

// File: verilog/digit_window.sv
`timescale 1ns/1ns
`include "score_defines.svh"

module digit_window #(
    parameter int DIGIT_SHIFT = 0,
    parameter int CORNER_X    = 0,
    parameter int CORNER_Y    = 0
) (
    input  score_pkg::pixel_t     pixel,
    output score_pkg::digit_hit_t hit
);

    localparam int WIDTH  = `GLYPH_W << DIGIT_SHIFT;
    localparam int HEIGHT = `GLYPH_H << DIGIT_SHIFT;

    logic [`COORD_W-1:0] dx;
    logic [`COORD_W-1:0] dy;
    logic [`COORD_W-1:0] dx_unscaled;
    logic [`COORD_W-1:0] dy_unscaled;
    logic                in_x;
    logic                in_y;

    assign dx = pixel.x - `COORD_W'(CORNER_X);
    assign dy = pixel.y - `COORD_W'(CORNER_Y);

    assign in_x = (pixel.x >= `COORD_W'(CORNER_X)) && (dx < `COORD_W'(WIDTH));
    assign in_y = (pixel.y >= `COORD_W'(CORNER_Y)) && (dy < `COORD_W'(HEIGHT));

    // Back to the 6x10 stroke grid.
    assign dx_unscaled = dx >> DIGIT_SHIFT;
    assign dy_unscaled = dy >> DIGIT_SHIFT;

    assign hit.hit   = in_x && in_y;
    assign hit.off_x = dx_unscaled[2:0];
    assign hit.off_y = dy_unscaled[3:0];

endmodule

// File: verilog/seven_seg_decoder.sv
`timescale 1ns/1ns

module seven_seg_decoder (
    input  score_pkg::bcd_t digit,
    output score_pkg::seg_t seg
);

    always_comb begin
        case (digit)
            4'd0:    seg = 7'b1000000;
            4'd1:    seg = 7'b1111001;
            4'd2:    seg = 7'b0100100;
            4'd3:    seg = 7'b0110000;
            4'd4:    seg = 7'b0011001;
            4'd5:    seg = 7'b0010010;
            4'd6:    seg = 7'b0000010;
            4'd7:    seg = 7'b1111000;
            4'd8:    seg = 7'b0000000;
            4'd9:    seg = 7'b0010000;
            default: seg = 7'b1111111; // Blank.
        endcase
    end

endmodule

// File: verilog/bcd_score_counter.sv
`timescale 1ns/1ns
`include "score_defines.svh"

module bcd_score_counter (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 point,
    input  logic [2:0]                           point_amount,
    input  logic                                 count_en,
    input  logic                                 score_clear,
    output score_pkg::bcd_t [`DIGIT_COUNT-1:0]   score_digits
);

    score_pkg::bcd_t [`DIGIT_COUNT-1:0] digits_nxt;
    logic [3:0] carry;
    logic [4:0] sum;

    // Ripple add through the digits, ones first.
    always_comb begin
        carry = {1'b0, point_amount};
        sum   = '0;
        for (int i = 0; i < `DIGIT_COUNT; i++) begin
            sum = {1'b0, score_digits[i]} + {1'b0, carry};
            if (sum > 5'd9) begin
                digits_nxt[i] = 4'(sum - 5'd10);
                carry         = 4'd1;
            end else begin
                digits_nxt[i] = sum[3:0];
                carry         = 4'd0;
            end
        end
        // Carry out of the top digit is dropped, wrapping at 1000.
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            score_digits <= '0;
        end else if (score_clear) begin
            score_digits <= '0; // Restart wins over a point.
        end else if (point && count_en) begin
            score_digits <= digits_nxt;
        end
    end

endmodule

// File: verilog/game_phase_fsm.sv
`timescale 1ns/1ns

module game_phase_fsm (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              game_over,
    input  logic              restart,
    output score_pkg::phase_e phase,
    output logic              count_en,
    output logic              score_clear
);

    score_pkg::phase_e phase_nxt;

    always_comb begin
        phase_nxt = phase;
        case (phase)
            score_pkg::PLAYING: begin
                if (game_over) begin
                    phase_nxt = score_pkg::OVER;
                end
            end
            score_pkg::OVER: begin
                if (restart) begin
                    phase_nxt = score_pkg::PLAYING;
                end
            end
            default: begin
                phase_nxt = score_pkg::PLAYING;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase <= score_pkg::PLAYING;
        end else begin
            phase <= phase_nxt;
        end
    end

    assign count_en    = (phase == score_pkg::PLAYING); // Score frozen at game over.
    assign score_clear = (phase == score_pkg::OVER) && restart;

endmodule

// File: verilog/score_pkg.sv
`include "score_defines.svh"

package score_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Pixel and window types
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [`COORD_W-1:0] x;
        logic [`COORD_W-1:0] y;
    } pixel_t;

    typedef struct packed {
        logic       hit;
        logic [2:0] off_x; // Unscaled column, 0 to 5.
        logic [3:0] off_y; // Unscaled row, 0 to 9.
    } digit_hit_t;

    ////////////////////////////////////////////////////////////////////////////
    // Game and digit types
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic {
        PLAYING = 1'b0,
        OVER    = 1'b1
    } phase_e;

    typedef logic [3:0] bcd_t;
    typedef logic [6:0] seg_t; // Active low, g f e d c b a.

endpackage

// File: verilog/score_defines.svh
`ifndef SCORE_DEFINES_SVH
`define SCORE_DEFINES_SVH

// Score width and pixel geometry.
`define DIGIT_COUNT 3
`define COORD_W     11

// Small glyph cell.
`define GLYPH_W     6
`define GLYPH_H     10

`define SMALL_X     600 // Ones digit, playing.
`define SMALL_Y     466

`define SCALE_SHIFT 3   // Large glyphs are 8x.
`define LARGE_X     400 // Ones digit, game over.
`define LARGE_Y     200

`define PLAY_RGB    8'h10
`define OVER_RGB    8'hE0

`endif
